// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_core_mem
RTL_TOP    := core_mem_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Simulator exit status carries the result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_core_mem.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module tb_core_mem
  import bus_pkg::*, core_pkg::*;
();

  localparam int          N_INST      = 300;
  localparam int          N_LSU       = 300;
  localparam int unsigned TIMEOUT_CYC = 200 * (N_INST + N_LSU);
  localparam logic [31:0] SEED        = 32'h6150;
  localparam logic [31:0] POLY        = 32'h8020_0003;
  localparam logic [31:0] LSU_BASE    = 32'h0001_0000;

  logic        clk;
  logic        rst;
  logic        inst_req_o;
  fetch_out_t  inst_o;
  logic        inst_ack_i;
  fetch_next_t next_i;
  logic        lsu_req_i;
  lsu_cmd_t    lsu_cmd_i;
  logic        lsu_ack_o;
  lsu_rsp_t    lsu_rsp_o;
  logic        mem_req_o;
  mem_req_t    mem_req_data_o;
  logic        mem_ack_i;
  mem_rsp_t    mem_rsp_i;

  logic [31:0] lfsr_q;
  int unsigned cyc;
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] port_mem [logic [31:0]];

  // Accesses expected on the memory port, with the cycle the arbiter can see them
  logic        if_pend;
  logic        ls_pend;
  mem_req_t    if_exp;
  mem_req_t    ls_exp;
  int unsigned if_vis;
  int unsigned ls_vis;
  int unsigned free_cyc;

  core_mem_top dut (
    .clk           (clk),
    .rst           (rst),
    .inst_req_o    (inst_req_o),
    .inst_o        (inst_o),
    .inst_ack_i    (inst_ack_i),
    .next_i        (next_i),
    .lsu_req_i     (lsu_req_i),
    .lsu_cmd_i     (lsu_cmd_i),
    .lsu_ack_o     (lsu_ack_o),
    .lsu_rsp_o     (lsu_rsp_o),
    .mem_req_o     (mem_req_o),
    .mem_req_data_o(mem_req_data_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rsp_i     (mem_rsp_i)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      b      = lfsr_q[0];
      lfsr_q = (lfsr_q >> 1) ^ (b ? POLY : 32'h0);
      r      = {r[30:0], b};
    end
    return r;
  endfunction

  // Unwritten words
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    if (ref_mem.exists(addr))
      return ref_mem[addr];
    return fill_word(addr);
  endfunction

  function automatic logic [31:0] port_word(input logic [31:0] addr);
    if (port_mem.exists(addr))
      return port_mem[addr];
    return fill_word(addr);
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] strb);
    logic [31:0] m;
    int          i;
    for (i = 0; i < 4; i++)
      m[8*i +: 8] = {8{strb[i]}};
    return m;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_fetch(input fetch_out_t exp, input fetch_out_t act);
    if (act !== exp)
    begin
      $display("Fail inst_o: expected %h, got %h", exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_lsu(input lsu_rsp_t exp, input lsu_rsp_t act);
    if (act !== exp)
    begin
      $display("Fail lsu_rsp_o: expected %h, got %h", exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_mem(input mem_req_t exp, input mem_req_t act);
    if (act !== exp)
    begin
      $display("Fail mem_req_data_o: expected %h, got %h", exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_reset_state();
    if (inst_req_o !== 1'b0 || lsu_ack_o !== 1'b0 || mem_req_o !== 1'b0)
      stop_run("Request or ack output not low during or right after reset");
  endtask

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc > TIMEOUT_CYC)
      stop_run("Timeout, the test did not finish in time");
  end

  // Memory port responder
  task automatic serve_memory();
    int          delay;
    int unsigned grant_cyc;
    mem_req_t    req;
    mem_req_t    exp;
    logic [31:0] rdata;
    forever
    begin
      @(posedge clk);
      if (mem_req_o)
      begin
        grant_cyc = cyc - 1;
        req       = mem_req_data_o;
        if (grant_cyc < free_cyc)
          stop_run("Memory request started while the previous access was open");
        // Load/store wins when both were visible at the grant
        if (ls_pend && ls_vis <= grant_cyc)
        begin
          exp     = ls_exp;
          ls_pend = 1'b0;
        end
        else if (if_pend && if_vis <= grant_cyc)
        begin
          exp     = if_exp;
          if_pend = 1'b0;
        end
        else
          stop_run("Memory request with no pending access");
        check_mem(exp, req);
        rdata = port_word(req.addr);
        if (req.we)
          port_mem[req.addr] = (rdata & ~byte_mask(req.wstrb))
                             | (req.wdata & byte_mask(req.wstrb));
        delay = rand_bits(4);
        repeat (delay)
        begin
          @(posedge clk);
          if (!mem_req_o || mem_req_data_o !== req)
            stop_run("Memory request dropped or changed before ack");
        end
        mem_ack_i <= 1'b1;
        mem_rsp_i <= '{rdata: rdata};
        @(posedge clk);
        while (mem_req_o) @(posedge clk);
        delay = rand_bits(4);
        repeat (delay)
        begin
          @(posedge clk);
          if (mem_req_o)
            stop_run("Memory request raised again while ack was high");
        end
        mem_ack_i <= 1'b0;
        free_cyc  = cyc + 2;
      end
    end
  endtask

  // Instruction consumer and next-pc model
  task automatic run_fetch();
    int          k;
    int          delay;
    logic [31:0] exp_pc;
    logic [31:0] offs;
    fetch_next_t nxt;
    exp_pc = `CORE_PC_INIT;
    for (k = 0; k < N_INST; k++)
    begin
      @(posedge clk);
      while (!inst_req_o) @(posedge clk);
      check_fetch('{pc: exp_pc, inst: ref_word(exp_pc)}, inst_o);
      delay = rand_bits(4);
      repeat (delay)
      begin
        @(posedge clk);
        if (!inst_req_o)
          stop_run("Instruction request dropped before ack");
      end
      offs       = rand_bits(10);
      nxt.jump   = (rand_bits(2) == 32'd0);
      nxt.target = `CORE_PC_INIT + (offs << 2);
      inst_ack_i <= 1'b1;
      next_i     <= nxt;
      exp_pc     = nxt.jump ? nxt.target : exp_pc + 32'd4;
      @(posedge clk);
      while (inst_req_o) @(posedge clk);
      delay = rand_bits(4);
      repeat (delay)
      begin
        @(posedge clk);
        if (inst_req_o)
          stop_run("Instruction request raised again while ack was high");
      end
      inst_ack_i <= 1'b0;
      if_exp     = '{addr: exp_pc, wdata: '0, wstrb: 4'hf, we: 1'b0};
      if_vis     = cyc + 3;
      if_pend    = 1'b1;
    end
  endtask

  // Load/store command source and its byte-lane model
  task automatic run_lsu();
    int          k;
    int          delay;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] word_addr;
    logic [31:0] data;
    logic [31:0] wdata;
    logic [31:0] mask;
    logic [31:0] lane_val;
    logic [1:0]  lane;
    logic [3:0]  strb;
    logic        is_store;
    mem_op_e     op;
    lsu_rsp_t    exp_rsp;
    for (k = 0; k < N_LSU; k++)
    begin
      delay = rand_bits(3);
      repeat (delay)
      begin
        @(posedge clk);
        if (lsu_ack_o)
          stop_run("Load/store ack high with no command pending");
      end
      r        = rand_bits(3);
      op       = mem_op_e'(r[2:0]);
      r        = rand_bits(2);
      lane     = r[1:0];
      strb     = 4'b0001;
      if (op inside {LH, LHU, SH})
      begin
        lane[0] = 1'b0;
        strb    = 4'b0011;
      end
      else if (op inside {LW, SW})
      begin
        lane = 2'b00;
        strb = 4'b1111;
      end
      addr      = LSU_BASE + (rand_bits(6) << 2) + {30'b0, lane};
      word_addr = {addr[31:2], 2'b00};
      data      = rand_bits(32);
      is_store  = op inside {SB, SH, SW};
      strb      = strb << lane;
      mask      = byte_mask(strb);
      wdata     = is_store ? (data << {lane, 3'b000}) & mask : 32'h0;
      lane_val  = ref_word(word_addr) >> {lane, 3'b000};
      case (op)
        LB:      exp_rsp.rdata = {{24{lane_val[7]}}, lane_val[7:0]};
        LBU:     exp_rsp.rdata = {24'b0, lane_val[7:0]};
        LH:      exp_rsp.rdata = {{16{lane_val[15]}}, lane_val[15:0]};
        LHU:     exp_rsp.rdata = {16'b0, lane_val[15:0]};
        LW:      exp_rsp.rdata = lane_val;
        default: exp_rsp.rdata = 32'h0;
      endcase
      if (is_store)
        ref_mem[word_addr] = (ref_word(word_addr) & ~mask) | wdata;
      lsu_cmd_i <= '{op: op, addr: addr, wdata: data};
      lsu_req_i <= 1'b1;
      ls_exp    = '{addr: word_addr, wdata: wdata, wstrb: strb, we: is_store};
      ls_vis    = cyc + 2;
      ls_pend   = 1'b1;
      @(posedge clk);
      while (!lsu_ack_o) @(posedge clk);
      check_lsu(exp_rsp, lsu_rsp_o);
      delay = rand_bits(4);
      repeat (delay)
      begin
        @(posedge clk);
        if (!lsu_ack_o)
          stop_run("Load/store ack dropped while the command was still requested");
      end
      lsu_req_i <= 1'b0;
      @(posedge clk);
      while (lsu_ack_o) @(posedge clk);
    end
  endtask

  initial
  begin
    lfsr_q     = SEED;
    cyc        = 0;
    rst        = 1'b1;
    inst_ack_i = 1'b0;
    next_i     = '0;
    lsu_req_i  = 1'b0;
    lsu_cmd_i  = '0;
    mem_ack_i  = 1'b0;
    mem_rsp_i  = '0;
    if_pend    = 1'b0;
    ls_pend    = 1'b0;
    free_cyc   = 0;
    repeat (5)
    begin
      @(posedge clk);
      if (cyc != 0)
        check_reset_state();
    end
    rst     <= 1'b0;
    // First fetch goes out right after reset
    if_exp  = '{addr: `CORE_PC_INIT, wdata: '0, wstrb: 4'hf, we: 1'b0};
    if_vis  = cyc + 2;
    if_pend = 1'b1;
    @(posedge clk);
    check_reset_state();
    fork
      serve_memory();
    join_none
    fork
      run_fetch();
      run_lsu();
    join
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== common/bus_pkg.sv ====
`include "core_params.svh"

package bus_pkg;

  // One access on the memory port
  typedef struct packed {
    logic [`CORE_ADDR_W-1:0] addr;
    logic [`CORE_DATA_W-1:0] wdata;
    logic [`CORE_STRB_W-1:0] wstrb;
    logic                    we;
  } mem_req_t;

  // Read data, valid while ack is high
  typedef struct packed {
    logic [`CORE_DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== common/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Bus geometry
`define CORE_ADDR_W 32
`define CORE_DATA_W 32

// Byte strobes per data word
`define CORE_STRB_W (`CORE_DATA_W / 8)

// Address bits that select a byte lane
`define CORE_LANE_W 2

// First instruction fetched after reset
`define CORE_PC_INIT 32'h8000_0000

// Sequential instruction step
`define CORE_INST_STEP 32'd4

// Instruction width
`define CORE_INST_W 32

`endif

// ==== common/core_pkg.sv ====
`include "core_params.svh"

package core_pkg;

  // Load and store flavours
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd3,
    LHU = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } mem_op_e;

  typedef struct packed {
    mem_op_e                 op;
    logic [`CORE_ADDR_W-1:0] addr;
    logic [`CORE_DATA_W-1:0] wdata;
  } lsu_cmd_t;

  // Zero for stores
  typedef struct packed {
    logic [`CORE_DATA_W-1:0] rdata;
  } lsu_rsp_t;

  typedef struct packed {
    logic [`CORE_ADDR_W-1:0] pc;
    logic [`CORE_INST_W-1:0] inst;
  } fetch_out_t;

  // Consumer's branch decision for the next fetch
  typedef struct packed {
    logic                    jump;
    logic [`CORE_ADDR_W-1:0] target;
  } fetch_next_t;

endpackage

// ==== fetch/fetch_unit.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_unit import bus_pkg::*, core_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  output logic        mem_req_o,
  output mem_req_t    mem_req_data_o,
  input  logic        mem_ack_i,
  input  mem_rsp_t    mem_rsp_i,
  output logic        inst_req_o,
  output fetch_out_t  inst_o,
  input  logic        inst_ack_i,
  input  fetch_next_t next_i
);

  typedef enum logic [1:0] {
    F_START,
    F_WAIT,
    F_OFFER,
    F_RELEASE
  } fetch_state_e;

  fetch_state_e            state_q;
  logic [`CORE_ADDR_W-1:0] pc_q;
  logic                    start;
  logic                    done;
  mem_req_t                fetch_req;
  mem_rsp_t                fetch_rsp;

  assign start = (state_q == F_START);

  // Full-word read at the current PC
  assign fetch_req = '{addr: pc_q, wdata: '0, wstrb: '1, we: 1'b0};

  assign inst_req_o = (state_q == F_OFFER);
  assign inst_o     = '{pc: pc_q, inst: fetch_rsp.rdata};

  fourphase_sender #(
    .req_t(mem_req_t),
    .rsp_t(mem_rsp_t)
  ) u_sender (
    .clk      (clk),
    .rst      (rst),
    .start_i  (start),
    .payload_i(fetch_req),
    .ack_i    (mem_ack_i),
    .rsp_i    (mem_rsp_i),
    .req_o    (mem_req_o),
    .payload_o(mem_req_data_o),
    .done_o   (done),
    .rsp_o    (fetch_rsp)
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= F_START;
      pc_q    <= `CORE_PC_INIT;
    end
    else
    begin
      case (state_q)
        F_START:   state_q <= F_WAIT;
        F_WAIT:    if (done) state_q <= F_OFFER;
        F_OFFER:
          if (inst_ack_i)
          begin
            state_q <= F_RELEASE;
            pc_q    <= next_i.jump ? next_i.target : pc_q + `CORE_INST_STEP;
          end
        F_RELEASE: if (!inst_ack_i) state_q <= F_START;
        default:   state_q <= F_START;
      endcase
    end
  end

  a_target_aligned: assert property (@(posedge clk) disable iff (rst)
    inst_req_o && inst_ack_i && next_i.jump |-> next_i.target[1:0] == 2'b00);

endmodule

// ==== filelist.f ====
+incdir+common
common/bus_pkg.sv
common/core_pkg.sv
hw/fourphase_sender.sv
fetch/fetch_unit.sv
lsu/lsu_unit.sv
hw/bus_arbiter.sv
hw/core_mem_top.sv
bench/tb_core_mem.sv

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     if_req_i,
  input  mem_req_t if_data_i,
  output logic     if_ack_o,
  output mem_rsp_t if_rsp_o,
  input  logic     ls_req_i,
  input  mem_req_t ls_data_i,
  output logic     ls_ack_o,
  output mem_rsp_t ls_rsp_o,
  output logic     mem_req_o,
  output mem_req_t mem_data_o,
  input  logic     mem_ack_i,
  input  mem_rsp_t mem_rsp_i
);

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_IF,
    GNT_LS
  } grant_e;

  grant_e grant_q;
  grant_e grant_d;
  logic   req_sel;

  // Load/store side wins a tie
  always_comb
  begin
    grant_d = grant_q;
    if (grant_q == GNT_NONE)
    begin
      if (ls_req_i)
        grant_d = GNT_LS;
      else if (if_req_i)
        grant_d = GNT_IF;
    end
    else if ((if_ack_o || ls_ack_o) && !mem_ack_i)
      grant_d = GNT_NONE;
  end

  always_comb
  begin
    case (grant_d)
      GNT_IF:  req_sel = if_req_i;
      GNT_LS:  req_sel = ls_req_i;
      default: req_sel = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant_q   <= GNT_NONE;
      mem_req_o <= 1'b0;
      if_ack_o  <= 1'b0;
      ls_ack_o  <= 1'b0;
    end
    else
    begin
      grant_q   <= grant_d;
      mem_req_o <= req_sel;
      if_ack_o  <= mem_ack_i && (grant_q == GNT_IF);
      ls_ack_o  <= mem_ack_i && (grant_q == GNT_LS);
    end
  end

  // Payload captured at grant, responses routed to the owner only
  always_ff @(posedge clk)
  begin
    if (grant_q == GNT_NONE)
      mem_data_o <= (grant_d == GNT_LS) ? ls_data_i : if_data_i;
    if (mem_ack_i && grant_q == GNT_IF)
      if_rsp_o <= mem_rsp_i;
    if (mem_ack_i && grant_q == GNT_LS)
      ls_rsp_o <= mem_rsp_i;
  end

  a_one_ack: assert property (@(posedge clk) disable iff (rst)
    $onehot0({if_ack_o, ls_ack_o}));

  a_grant_held: assert property (@(posedge clk) disable iff (rst)
    mem_req_o || mem_ack_i |=> $stable(grant_q));

endmodule

// ==== hw/core_mem_top.sv ====
`timescale 1ns/1ps

module core_mem_top import bus_pkg::*, core_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  output logic        inst_req_o,
  output fetch_out_t  inst_o,
  input  logic        inst_ack_i,
  input  fetch_next_t next_i,
  input  logic        lsu_req_i,
  input  lsu_cmd_t    lsu_cmd_i,
  output logic        lsu_ack_o,
  output lsu_rsp_t    lsu_rsp_o,
  output logic        mem_req_o,
  output mem_req_t    mem_req_data_o,
  input  logic        mem_ack_i,
  input  mem_rsp_t    mem_rsp_i
);

  // Fetch side of the arbiter
  logic     if_req;
  logic     if_ack;
  mem_req_t if_mem_req;
  mem_rsp_t if_mem_rsp;

  // Load/store side of the arbiter
  logic     ls_req;
  logic     ls_ack;
  mem_req_t ls_mem_req;
  mem_rsp_t ls_mem_rsp;

  fetch_unit u_fetch (
    .clk           (clk),
    .rst           (rst),
    .mem_req_o     (if_req),
    .mem_req_data_o(if_mem_req),
    .mem_ack_i     (if_ack),
    .mem_rsp_i     (if_mem_rsp),
    .inst_req_o    (inst_req_o),
    .inst_o        (inst_o),
    .inst_ack_i    (inst_ack_i),
    .next_i        (next_i)
  );

  lsu_unit u_lsu (
    .clk           (clk),
    .rst           (rst),
    .cmd_req_i     (lsu_req_i),
    .cmd_i         (lsu_cmd_i),
    .cmd_ack_o     (lsu_ack_o),
    .rsp_o         (lsu_rsp_o),
    .mem_req_o     (ls_req),
    .mem_req_data_o(ls_mem_req),
    .mem_ack_i     (ls_ack),
    .mem_rsp_i     (ls_mem_rsp)
  );

  bus_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .if_req_i  (if_req),
    .if_data_i (if_mem_req),
    .if_ack_o  (if_ack),
    .if_rsp_o  (if_mem_rsp),
    .ls_req_i  (ls_req),
    .ls_data_i (ls_mem_req),
    .ls_ack_o  (ls_ack),
    .ls_rsp_o  (ls_mem_rsp),
    .mem_req_o (mem_req_o),
    .mem_data_o(mem_req_data_o),
    .mem_ack_i (mem_ack_i),
    .mem_rsp_i (mem_rsp_i)
  );

endmodule

// ==== hw/fourphase_sender.sv ====
`timescale 1ns/1ps

module fourphase_sender #(
  parameter type req_t = logic,
  parameter type rsp_t = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic start_i,
  input  req_t payload_i,
  input  logic ack_i,
  input  rsp_t rsp_i,
  output logic req_o,
  output req_t payload_o,
  output logic done_o,
  output rsp_t rsp_o
);

  typedef enum logic {
    S_IDLE,
    S_BUSY
  } state_e;

  state_e state_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= S_IDLE;
      req_o   <= 1'b0;
      done_o  <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      case (state_q)
        S_IDLE:
          if (start_i)
          begin
            state_q <= S_BUSY;
            req_o   <= 1'b1;
          end
        S_BUSY:
          if (req_o && ack_i)
            req_o <= 1'b0;
          else if (!req_o && !ack_i)
          begin
            // Responder has released ack
            state_q <= S_IDLE;
            done_o  <= 1'b1;
          end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == S_IDLE && start_i)
      payload_o <= payload_i;
    if (state_q == S_BUSY && req_o && ack_i)
      rsp_o <= rsp_i;
  end

  a_req_waits_ack: assert property (@(posedge clk) disable iff (rst)
    $fell(req_o) |-> $past(ack_i));

  a_payload_stable: assert property (@(posedge clk) disable iff (rst)
    req_o && $past(req_o) |-> $stable(payload_o));

endmodule

// ==== lsu/lsu_unit.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module lsu_unit import bus_pkg::*, core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     cmd_req_i,
  input  lsu_cmd_t cmd_i,
  output logic     cmd_ack_o,
  output lsu_rsp_t rsp_o,
  output logic     mem_req_o,
  output mem_req_t mem_req_data_o,
  input  logic     mem_ack_i,
  input  mem_rsp_t mem_rsp_i
);

  typedef enum logic [1:0] {
    L_IDLE,
    L_BUSY,
    L_ACK
  } lsu_state_e;

  lsu_state_e              state_q;
  logic                    start;
  logic                    done;
  logic                    is_store;
  logic                    aligned;
  logic [`CORE_LANE_W-1:0] lane;
  logic [`CORE_LANE_W-1:0] lane_q;
  mem_op_e                 op_q;
  logic [`CORE_STRB_W-1:0] size_strb;
  logic [`CORE_DATA_W-1:0] size_data;
  logic [`CORE_DATA_W-1:0] rdata_lane;
  logic [`CORE_DATA_W-1:0] ext_data;
  mem_req_t                ls_req;
  mem_rsp_t                ls_rsp;

  assign start    = (state_q == L_IDLE) && cmd_req_i;
  assign lane     = cmd_i.addr[`CORE_LANE_W-1:0];
  assign is_store = cmd_i.op inside {SB, SH, SW};

  // Access size decides strobe width, data width and alignment
  always_comb
  begin
    case (cmd_i.op)
      LB, LBU, SB:
      begin
        size_strb = 4'b0001;
        size_data = {24'b0, cmd_i.wdata[7:0]};
        aligned   = 1'b1;
      end
      LH, LHU, SH:
      begin
        size_strb = 4'b0011;
        size_data = {16'b0, cmd_i.wdata[15:0]};
        aligned   = !lane[0];
      end
      default:
      begin
        size_strb = 4'b1111;
        size_data = cmd_i.wdata;
        aligned   = (lane == '0);
      end
    endcase
  end

  assign ls_req = '{
    addr:  {cmd_i.addr[`CORE_ADDR_W-1:`CORE_LANE_W], {`CORE_LANE_W{1'b0}}},
    wdata: is_store ? size_data << {lane, 3'b000} : '0,
    wstrb: size_strb << lane,
    we:    is_store
  };

  fourphase_sender #(
    .req_t(mem_req_t),
    .rsp_t(mem_rsp_t)
  ) u_sender (
    .clk      (clk),
    .rst      (rst),
    .start_i  (start),
    .payload_i(ls_req),
    .ack_i    (mem_ack_i),
    .rsp_i    (mem_rsp_i),
    .req_o    (mem_req_o),
    .payload_o(mem_req_data_o),
    .done_o   (done),
    .rsp_o    (ls_rsp)
  );

  // Lane extraction and extension of the loaded word
  assign rdata_lane = ls_rsp.rdata >> {lane_q, 3'b000};

  always_comb
  begin
    case (op_q)
      LB:      ext_data = {{24{rdata_lane[7]}}, rdata_lane[7:0]};
      LBU:     ext_data = {24'b0, rdata_lane[7:0]};
      LH:      ext_data = {{16{rdata_lane[15]}}, rdata_lane[15:0]};
      LHU:     ext_data = {16'b0, rdata_lane[15:0]};
      LW:      ext_data = rdata_lane;
      default: ext_data = '0;
    endcase
  end

  assign cmd_ack_o = (state_q == L_ACK);

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= L_IDLE;
    else
    begin
      case (state_q)
        L_IDLE:  if (cmd_req_i) state_q <= L_BUSY;
        L_BUSY:  if (done) state_q <= L_ACK;
        L_ACK:   if (!cmd_req_i) state_q <= L_IDLE;
        default: state_q <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      op_q   <= cmd_i.op;
      lane_q <= lane;
    end
    if (state_q == L_BUSY && done)
      rsp_o <= '{rdata: ext_data};
  end

  a_cmd_aligned: assert property (@(posedge clk) disable iff (rst)
    $rose(cmd_req_i) |-> aligned);

endmodule
